/* hw/riscv_pkg.sv */
package riscv_pkg;

    localparam int XLEN = 32;
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0000;

    typedef enum logic [2:0] {
        FETCH,
        DECODE,
        EXECUTE,
        MEMORY,
        WRITEBACK
    } state_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_I_TYPE = 7'b0010011,
        OP_R_TYPE = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    // arithmetic funct3
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SR      = 3'b101;  // srl / sra by funct7
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // branch funct3
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    // load / store size funct3
    localparam logic [2:0] F3_B  = 3'b000;
    localparam logic [2:0] F3_H  = 3'b001;
    localparam logic [2:0] F3_W  = 3'b010;
    localparam logic [2:0] F3_BU = 3'b100;
    localparam logic [2:0] F3_HU = 3'b101;

endpackage

/* hw/state_machine.sv */
module state_machine (
    input  logic                clk,
    input  logic                rst_n,
    input  riscv_pkg::opcode_t  opcode,
    input  logic                fetch_done,
    input  logic                mem_done,
    output riscv_pkg::state_t   now_state,
    output logic                stage_finish
);
    import riscv_pkg::*;

    state_t next_state;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            now_state <= FETCH;
        end else if (stage_finish) begin
            now_state <= next_state;
        end
    end

    // only the memory stages wait on a handshake
    always_comb begin
        case (now_state)
            FETCH:   stage_finish = fetch_done;
            MEMORY:  stage_finish = mem_done;
            default: stage_finish = 1'b1;
        endcase
    end

    always_comb begin
        next_state = FETCH;
        case (now_state)
            FETCH:   next_state = DECODE;
            DECODE:  next_state = EXECUTE;
            EXECUTE: begin
                case (opcode)
                    OP_BRANCH: next_state = FETCH;      // done after compare
                    OP_LOAD,
                    OP_STORE:  next_state = MEMORY;
                    OP_R_TYPE,
                    OP_I_TYPE,
                    OP_JAL,
                    OP_JALR,
                    OP_LUI,
                    OP_AUIPC:  next_state = WRITEBACK;
                    default:   next_state = FETCH;      // unknown opcode dropped
                endcase
            end
            MEMORY:  next_state = (opcode == OP_LOAD) ? WRITEBACK : FETCH;
            default: next_state = FETCH;
        endcase
    end

endmodule

/* hw/fetch_unit.sv */
module fetch_unit (
    input  logic                        clk,
    input  logic                        rst_n,
    input  riscv_pkg::state_t           now_state,
    input  logic                        stage_finish,
    input  logic                        pc_load,
    input  logic [riscv_pkg::XLEN-1:0]  pc_target,
    output logic                        imem_req,
    output logic [riscv_pkg::XLEN-1:0]  imem_addr,
    input  logic                        imem_ready,
    input  logic [riscv_pkg::XLEN-1:0]  imem_rdata,
    output logic [riscv_pkg::XLEN-1:0]  pc,
    output logic [riscv_pkg::XLEN-1:0]  instr,
    output logic                        fetch_done
);
    import riscv_pkg::*;

    logic [XLEN-1:0] fetch_pc;  // address of the next instruction

    // request stays up for the whole FETCH visit
    assign imem_req   = (now_state == FETCH);
    assign imem_addr  = fetch_pc;
    assign fetch_done = imem_req && imem_ready;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            fetch_pc <= RESET_PC;
            pc       <= RESET_PC;
        end else if (fetch_done) begin
            pc       <= fetch_pc;
            fetch_pc <= fetch_pc + 32'd4;  // sequential successor
        end else if (now_state == EXECUTE && stage_finish && pc_load) begin
            fetch_pc <= pc_target;  // taken branch or jump
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) begin
            instr <= imem_rdata;
        end
    end

endmodule

/* hw/instr_decoder.sv */
module instr_decoder (
    input  logic [riscv_pkg::XLEN-1:0]  instr,
    output riscv_pkg::opcode_t          opcode,
    output logic [4:0]                  rd,
    output logic [4:0]                  rs1,
    output logic [4:0]                  rs2,
    output logic [2:0]                  funct3,
    output logic [riscv_pkg::XLEN-1:0]  imm,
    output riscv_pkg::alu_op_t          alu_op
);
    import riscv_pkg::*;

    logic [6:0] funct7;

    assign opcode = opcode_t'(instr[6:0]);
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    always_comb begin
        case (opcode)
            OP_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            OP_BRANCH: imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            OP_LUI,
            OP_AUIPC:  imm = {instr[31:12], 12'b0};
            OP_JAL:    imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            default:   imm = {{20{instr[31]}}, instr[31:20]};  // I format
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;  // address math, lui, auipc
        if (opcode == OP_R_TYPE || opcode == OP_I_TYPE) begin
            case (funct3)
                F3_ADD_SUB: begin
                    // subi does not exist
                    if (opcode == OP_R_TYPE && funct7[5]) begin
                        alu_op = ALU_SUB;
                    end else begin
                        alu_op = ALU_ADD;
                    end
                end
                F3_SLL:  alu_op = ALU_SLL;
                F3_SLT:  alu_op = ALU_SLT;
                F3_SLTU: alu_op = ALU_SLTU;
                F3_XOR:  alu_op = ALU_XOR;
                F3_SR:   alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
                F3_OR:   alu_op = ALU_OR;
                F3_AND:  alu_op = ALU_AND;
                default: alu_op = ALU_ADD;
            endcase
        end
    end

endmodule

/* hw/reg_file.sv */
module reg_file (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic [4:0]                  rs1,
    input  logic [4:0]                  rs2,
    output logic [riscv_pkg::XLEN-1:0]  rs1_data,
    output logic [riscv_pkg::XLEN-1:0]  rs2_data,
    input  logic                        wb_en,
    input  logic [4:0]                  wb_rd,
    input  logic [riscv_pkg::XLEN-1:0]  wb_data
);
    import riscv_pkg::*;

    logic [XLEN-1:0] regs [1:31];

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_rd != 5'd0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];  // x0 hardwired
    assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

/* hw/alu.sv */
module alu (
    input  riscv_pkg::alu_op_t          alu_op,
    input  logic [2:0]                  funct3,
    input  logic [riscv_pkg::XLEN-1:0]  a,
    input  logic [riscv_pkg::XLEN-1:0]  b,
    output logic [riscv_pkg::XLEN-1:0]  result,
    output logic                        branch_taken
);
    import riscv_pkg::*;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << b[4:0];
            ALU_SLT:  result = {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: result = {31'b0, a < b};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> b[4:0];
            ALU_SRA:  result = $unsigned($signed(a) >>> b[4:0]);
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = a + b;
        endcase
    end

    // compare on rs1 / rs2, only meaningful for branches
    always_comb begin
        case (funct3)
            F3_BEQ:  branch_taken = (a == b);
            F3_BNE:  branch_taken = (a != b);
            F3_BLT:  branch_taken = $signed(a) < $signed(b);
            F3_BGE:  branch_taken = $signed(a) >= $signed(b);
            F3_BLTU: branch_taken = a < b;
            F3_BGEU: branch_taken = a >= b;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

/* hw/mem_access.sv */
module mem_access (
    input  logic                        clk,
    input  logic                        rst_n,
    input  riscv_pkg::state_t           now_state,
    input  riscv_pkg::opcode_t          opcode,
    input  logic [2:0]                  funct3,
    input  logic [riscv_pkg::XLEN-1:0]  addr,
    input  logic [riscv_pkg::XLEN-1:0]  store_data,
    output logic                        dmem_req,
    output logic                        dmem_we,
    output logic [riscv_pkg::XLEN-1:0]  dmem_addr,
    output logic [3:0]                  dmem_be,
    output logic [riscv_pkg::XLEN-1:0]  dmem_wdata,
    input  logic                        dmem_ready,
    input  logic [riscv_pkg::XLEN-1:0]  dmem_rdata,
    output logic [riscv_pkg::XLEN-1:0]  load_data,
    output logic                        mem_done
);
    import riscv_pkg::*;

    logic [XLEN-1:0] rdata_shifted;

    assign dmem_req  = (now_state == MEMORY);
    assign dmem_we   = dmem_req && (opcode == OP_STORE);
    assign dmem_addr = {addr[XLEN-1:2], 2'b00};
    assign mem_done  = dmem_req && dmem_ready;

    // replicate the store data so every lane carries it
    always_comb begin
        case (funct3)
            F3_B: begin
                dmem_be    = 4'b0001 << addr[1:0];
                dmem_wdata = {4{store_data[7:0]}};
            end
            F3_H: begin
                dmem_be    = 4'b0011 << {addr[1], 1'b0};
                dmem_wdata = {2{store_data[15:0]}};
            end
            default: begin
                dmem_be    = 4'b1111;
                dmem_wdata = store_data;
            end
        endcase
    end

    assign rdata_shifted = dmem_rdata >> {addr[1:0], 3'b000};  // addressed lane to bit 0

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            load_data <= '0;
        end else if (mem_done && opcode == OP_LOAD) begin
            case (funct3)
                F3_B:    load_data <= {{24{rdata_shifted[7]}}, rdata_shifted[7:0]};
                F3_H:    load_data <= {{16{rdata_shifted[15]}}, rdata_shifted[15:0]};
                F3_BU:   load_data <= {24'b0, rdata_shifted[7:0]};
                F3_HU:   load_data <= {16'b0, rdata_shifted[15:0]};
                F3_W:    load_data <= dmem_rdata;
                default: load_data <= dmem_rdata;
            endcase
        end
    end

endmodule

/* hw/riscv_core.sv */
module riscv_core (
    input  logic                        clk,
    input  logic                        rst_n,
    output logic                        imem_req,
    output logic [riscv_pkg::XLEN-1:0]  imem_addr,
    input  logic                        imem_ready,
    input  logic [riscv_pkg::XLEN-1:0]  imem_rdata,
    output logic                        dmem_req,
    output logic                        dmem_we,
    output logic [riscv_pkg::XLEN-1:0]  dmem_addr,
    output logic [3:0]                  dmem_be,
    output logic [riscv_pkg::XLEN-1:0]  dmem_wdata,
    input  logic                        dmem_ready,
    input  logic [riscv_pkg::XLEN-1:0]  dmem_rdata,
    output logic                        retire_valid,
    output logic [riscv_pkg::XLEN-1:0]  retire_pc,
    output logic                        retire_we,
    output logic [4:0]                  retire_rd,
    output logic [riscv_pkg::XLEN-1:0]  retire_data
);
    import riscv_pkg::*;

    state_t          now_state;
    opcode_t         opcode;
    alu_op_t         alu_op;
    logic            stage_finish;
    logic            fetch_done;
    logic            mem_done;
    logic [4:0]      rd;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [2:0]      funct3;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    logic [XLEN-1:0] op_rs1;
    logic [XLEN-1:0] op_rs2;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] exe_result;
    logic [XLEN-1:0] load_data;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] pc_target;
    logic            branch_taken;
    logic            is_jump;
    logic            pc_load;
    logic            wb_en;

    state_machine i_state_machine (.*);
    fetch_unit    i_fetch_unit (.*);
    instr_decoder i_instr_decoder (.*);

    reg_file i_reg_file (
        .clk, .rst_n, .rs1, .rs2, .rs1_data, .rs2_data,
        .wb_en, .wb_rd(rd), .wb_data
    );

    alu i_alu (
        .alu_op, .funct3, .a(alu_a), .b(alu_b), .result(alu_result), .branch_taken
    );

    mem_access i_mem_access (
        .clk, .rst_n, .now_state, .opcode, .funct3,
        .addr(exe_result), .store_data(op_rs2),
        .dmem_req, .dmem_we, .dmem_addr, .dmem_be, .dmem_wdata,
        .dmem_ready, .dmem_rdata, .load_data, .mem_done
    );

    // operands sampled in DECODE
    always_ff @(posedge clk) begin
        if (now_state == DECODE) begin
            op_rs1 <= rs1_data;
            op_rs2 <= rs2_data;
        end
    end

    assign alu_a = (opcode == OP_AUIPC) ? pc :
                   (opcode == OP_LUI)   ? '0 : op_rs1;
    assign alu_b = (opcode == OP_R_TYPE || opcode == OP_BRANCH) ? op_rs2 : imm;

    assign is_jump   = (opcode == OP_JAL) || (opcode == OP_JALR);
    assign pc_load   = is_jump || (opcode == OP_BRANCH && branch_taken);
    assign pc_target = (opcode == OP_JALR) ? {alu_result[XLEN-1:1], 1'b0} : pc + imm;

    always_ff @(posedge clk) begin
        if (now_state == EXECUTE) begin
            exe_result <= is_jump ? pc + 32'd4 : alu_result;  // link address for jumps
        end
    end

    assign wb_en   = (now_state == WRITEBACK);
    assign wb_data = (opcode == OP_LOAD) ? load_data : exe_result;

    // last cycle of the final state
    assign retire_valid = stage_finish && (wb_en ||
                          (now_state == MEMORY && opcode == OP_STORE) ||
                          (now_state == EXECUTE && opcode == OP_BRANCH));
    assign retire_pc    = pc;
    assign retire_we    = wb_en;
    assign retire_rd    = rd;
    assign retire_data  = wb_data;

endmodule

/* test/tb_riscv_core.sv */
module tb_riscv_core;
    import riscv_pkg::*;

    localparam int N_INSTR = 300;
    localparam int LIMIT   = 16 * N_INSTR + 40;

    logic clk = 1'b0;
    logic rst_n;
    logic imem_req, imem_ready, dmem_req, dmem_we, dmem_ready;
    logic [31:0] imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
    logic [3:0] dmem_be;
    logic retire_valid, retire_we;
    logic [4:0] retire_rd;
    logic [31:0] retire_pc, retire_data;

    logic [31:0] prog [0:255];
    logic [31:0] dmem [0:255];   // memory seen by the DUT
    logic [31:0] mmem [0:255];   // model memory
    logic [31:0] mreg [0:31];
    logic [31:0] mpc;
    logic [31:0] rng, irng, drng;
    int imem_wait, dmem_wait, cycles, retired, checks, errors, cur;
    int cat_checks [0:4];
    int cat_errs [0:4];
    bit fetched_once;

    riscv_core i_riscv_core (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        cat_checks[cur]++;
        if (exp !== act) begin
            errors++;
            cat_errs[cur]++;
            $display("error %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic build_program();
        logic [31:0] r;
        logic [31:0] off;
        logic [11:0] imm;
        logic [2:0] f3;
        int tgt;
        for (int i = 0; i < 256; i++) begin
            rng = xorshift(rng);
            r = rng;
            tgt = int'(r[31:24]);
            if (tgt == i) tgt = (i + 1) % 256;  // no self loops
            off = (tgt - i) * 4;
            f3 = r[14:12];
            case (r[2:0])
                3'd0: prog[i] = {(f3 == 3'd0 || f3 == 3'd5) && r[30] ? 7'h20 : 7'h00,
                                 r[24:20], r[19:15], f3, r[11:7], 7'h33};
                3'd1, 3'd7: begin
                    imm = r[31:20];
                    if (f3 == 3'd1) imm[11:5] = 7'h00;
                    if (f3 == 3'd5) imm[11:5] = r[30] ? 7'h20 : 7'h00;
                    prog[i] = {imm, r[19:15], f3, r[11:7], 7'h13};
                end
                3'd2: prog[i] = {r[31:12], r[11:7], r[3] ? 7'h17 : 7'h37};
                3'd3: begin
                    if (r[3])
                        prog[i] = {off[20], off[10:1], off[11], off[19:12], r[11:7], 7'h6f};
                    else
                        prog[i] = {2'b00, tgt[7:0], 2'b00, 5'd0, 3'd0, r[11:7], 7'h67};
                end
                3'd4: begin
                    if (f3 == 3'd2 || f3 == 3'd3) f3 = {1'b1, f3[0], 1'b0};
                    prog[i] = {off[12], off[10:5], r[24:20], r[19:15], f3, off[4:1],
                               off[11], 7'h63};
                end
                3'd5: begin
                    f3 = (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3;
                    imm = {2'b00, r[31:22]};
                    imm = (f3[1:0] == 2'd2) ? (imm & 12'hffc) :
                          (f3[1:0] == 2'd1) ? (imm & 12'hffe) : imm;
                    prog[i] = {imm, 5'd0, f3, r[11:7], 7'h03};
                end
                default: begin
                    f3 = {1'b0, (f3[1:0] == 2'd3) ? 2'd2 : f3[1:0]};
                    imm = {2'b00, r[31:22]};
                    imm = (f3 == 3'd2) ? (imm & 12'hffc) : (f3 == 3'd1) ? (imm & 12'hffe) : imm;
                    prog[i] = {imm[11:5], r[24:20], 5'd0, f3, imm[4:0], 7'h23};
                end
            endcase
        end
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // ISA model, one instruction per retire pulse
    task automatic model_step();
        logic [31:0] ins, a, b, iimm, simm, bimm, jimm, nxt, val, addr, lane;
        logic [4:0] rd;
        logic [2:0] f3;
        logic we, taken;
        ins  = prog[mpc[9:2]];
        rd   = ins[11:7];
        f3   = ins[14:12];
        a    = mreg[ins[19:15]];
        b    = mreg[ins[24:20]];
        iimm = {{20{ins[31]}}, ins[31:20]};
        simm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        bimm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        jimm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt  = mpc + 4;
        we   = 1'b1;
        val  = 32'd0;
        cur  = (ins[6:0] == 7'h63) ? 2 : (ins[6:0] == 7'h03 || ins[6:0] == 7'h23) ? 3 :
               (ins[6:0] == 7'h33 || ins[6:0] == 7'h13) ? 0 : 1;
        if (retired == 0) begin
            check("first_retire_pc", mpc, retire_pc);
        end else begin
            check("retire_pc", mpc, retire_pc);
        end
        case (ins[6:0])
            7'h37: val = {ins[31:12], 12'b0};
            7'h17: val = mpc + {ins[31:12], 12'b0};
            7'h6f: begin
                val = mpc + 4;
                nxt = mpc + jimm;
            end
            7'h67: begin
                val = mpc + 4;
                nxt = (a + iimm) & ~32'd1;
            end
            7'h63: begin
                we = 1'b0;
                case (f3)
                    3'd0: taken = a == b;
                    3'd1: taken = a != b;
                    3'd4: taken = $signed(a) < $signed(b);
                    3'd5: taken = $signed(a) >= $signed(b);
                    3'd6: taken = a < b;
                    default: taken = a >= b;
                endcase
                if (taken) nxt = mpc + bimm;
            end
            7'h03: begin
                addr = a + iimm;
                lane = mmem[addr[9:2]] >> (8 * int'(addr[1:0]));
                case (f3)
                    3'd0: val = {{24{lane[7]}}, lane[7:0]};
                    3'd1: val = {{16{lane[15]}}, lane[15:0]};
                    3'd4: val = {24'b0, lane[7:0]};
                    3'd5: val = {16'b0, lane[15:0]};
                    default: val = lane;
                endcase
            end
            7'h23: begin
                we = 1'b0;
                addr = a + simm;
                for (int k = 0; k < 4; k++) begin
                    if (f3 == 3'd2 || (f3 == 3'd1 && k[1] == addr[1]) || k[1:0] == addr[1:0])
                        mmem[addr[9:2]][k*8 +: 8] = b[((k * 8) % (8 << f3)) +: 8];
                end
                check("store_word", mmem[addr[9:2]], dmem[addr[9:2]]);
            end
            7'h13: val = alu_model(f3, f3 == 3'd5 && ins[30], a, iimm);
            default: val = alu_model(f3, ins[30], a, b);
        endcase
        check("retire_we", {31'b0, we}, {31'b0, retire_we});
        if (we) begin
            check("retire_rd", {27'b0, rd}, {27'b0, retire_rd});
            check("retire_data", val, retire_data);
            if (rd != 5'd0) mreg[rd] = val;  // x0 stays zero
        end
        mpc = nxt;
    endtask

    // instruction memory, 1 to 4 cycles
    always @(posedge clk) begin
        imem_ready <= 1'b0;
        if (rst_n && imem_req && !imem_ready) begin
            if (imem_wait == 0) begin
                imem_ready <= 1'b1;
                imem_rdata <= prog[imem_addr[9:2]];
                irng = xorshift(irng);
                imem_wait <= int'(irng[1:0]);
            end else begin
                imem_wait <= imem_wait - 1;
            end
        end
    end

    // data memory with byte enables
    always @(posedge clk) begin
        dmem_ready <= 1'b0;
        if (rst_n && dmem_req && !dmem_ready) begin
            if (dmem_wait == 0) begin
                dmem_ready <= 1'b1;
                dmem_rdata <= dmem[dmem_addr[9:2]];
                for (int k = 0; k < 4; k++) begin
                    if (dmem_we && dmem_be[k]) begin
                        dmem[dmem_addr[9:2]][k*8 +: 8] <= dmem_wdata[k*8 +: 8];
                    end
                end
                drng = xorshift(drng);
                dmem_wait <= int'(drng[1:0]);
            end else begin
                dmem_wait <= dmem_wait - 1;
            end
        end
    end

    always @(negedge clk) begin
        if (rst_n && !fetched_once) begin
            cur = 4;
            check("reset_dmem_req", 32'd0, {31'b0, dmem_req});
            check("reset_retire", 32'd0, {31'b0, retire_valid});
            fetched_once = imem_ready;
        end
        if (rst_n && retire_valid && retired < N_INSTR) begin
            model_step();
            retired++;
            if (retired == 1)
                $display("reset: %0d checks, %0d errors", cat_checks[4], cat_errs[4]);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: core stalled after %0d of %0d instructions", retired, N_INSTR);
            $display("Test FAILED");
            $finish;
        end
    end

    initial begin
        rst_n = 1'b0;
        imem_ready = 1'b0;
        imem_rdata = '0;
        dmem_ready = 1'b0;
        dmem_rdata = '0;
        cycles = 0;
        retired = 0;
        rng = 32'd30;
        irng = xorshift(32'd31);
        drng = xorshift(32'd32);
        imem_wait = 1;
        dmem_wait = 2;
        mpc = RESET_PC;
        for (int i = 0; i < 32; i++) mreg[i] = '0;
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 32'h9e37_79b9 * (i + 1) ^ (i << 20);
            mmem[i] = dmem[i];
        end
        build_program();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        wait (retired >= N_INSTR);
        @(posedge clk);
        $display("arithmetic: %0d checks, %0d errors", cat_checks[0], cat_errs[0]);
        $display("upper_and_jumps: %0d checks, %0d errors", cat_checks[1], cat_errs[1]);
        $display("branches: %0d checks, %0d errors", cat_checks[2], cat_errs[2]);
        $display("loads_stores: %0d checks, %0d errors", cat_checks[3], cat_errs[3]);
        $display("random_mix: %0d retired, %0d checks, %0d errors", retired, checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/riscv_pkg.sv
hw/state_machine.sv
hw/fetch_unit.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/mem_access.sv
hw/riscv_core.sv
test/tb_riscv_core.sv

/* Makefile */
TOP = tb_riscv_core

.PHONY: compile run clean

compile:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q "Test FAILED" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Test OK" sim.log

clean:
	rm -rf obj_dir sim.log
